// ==== Bender.yml ====
package:
  name: scalar_unit

sources:
  - logic/isa_pkg.sv
  - logic/pipe_pkg.sv
  - logic/instr_mem.sv
  - logic/fetch_unit.sv
  - logic/hazard_check.sv
  - logic/reg_bank.sv
  - logic/scalar_alu.sv
  - logic/scalar_unit.sv
  - target: test
    files:
      - test/clock_gen.sv
      - test/scalar_unit_tb.sv

// ==== compile.f ====
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/instr_mem.sv
logic/fetch_unit.sv
logic/hazard_check.sv
logic/reg_bank.sv
logic/scalar_alu.sv
logic/scalar_unit.sv
test/clock_gen.sv
test/scalar_unit_tb.sv

// ==== logic/fetch_unit.sv ====
/*
 * Program counter and run control.
 * IMEM_DEPTH must be a power of two; the PC wraps at the end of memory.
 * start is ignored while running. A redirect or a halt from execute takes
 * priority over a stall, and the word being fetched at that point is dropped.
 */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit #(
	parameter int IMEM_DEPTH = 64
) (
	input  wire                            clock,
	input  wire                            reset,
	input  wire                            start,
	input  wire                            stall,
	input  wire                            redirect,
	input  wire  [$clog2(IMEM_DEPTH)-1:0]  redirect_addr,
	input  wire                            halt_exec,
	output logic [$clog2(IMEM_DEPTH)-1:0]  pc,
	output logic                           fetch_en,
	output logic                           fetch_valid,
	output logic                           running,
	output logic                           halted
);
	import pipe_pkg::*;

	run_state_t state;

	assign running  = (state == st_run);
	assign halted   = (state == st_halted);
	assign fetch_en = running && !stall && !halt_exec;

	//////////////////////////////
	// Run state and PC
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= st_idle;
			pc          <= '0;
			fetch_valid <= 1'b0;
		end else begin
			case (state)
				st_idle, st_halted: begin
					fetch_valid <= 1'b0;
					if (start) begin
						state <= st_run;
						pc    <= '0;
					end
				end
				st_run: begin
					if (halt_exec) begin
						state       <= st_halted;
						fetch_valid <= 1'b0;
					end else if (redirect) begin
						pc          <= redirect_addr;
						fetch_valid <= 1'b0;
					end else if (!stall) begin
						pc          <= pc + 1'b1;
						fetch_valid <= 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	a_redirect_in_run: assert property (@(posedge clock) disable iff (reset)
		redirect |-> state == st_run);

endmodule

`default_nettype wire

// ==== logic/hazard_check.sv ====
/*
 * Scoreboard with one pending bit per register.
 * There is no operand forwarding: a dependent instruction waits until the
 * write-back of its source has retired. A pending destination also stalls.
 */
`timescale 1ns/100ps
`default_nettype none

module hazard_check (
	input  wire                                clock,
	input  wire                                reset,
	input  wire                                issue_valid,
	input  wire  isa_pkg::opcode_t             opcode,
	input  wire  [isa_pkg::REG_IDX_WIDTH-1:0]  dst_idx,
	input  wire  [isa_pkg::REG_IDX_WIDTH-1:0]  src1_idx,
	input  wire  [isa_pkg::REG_IDX_WIDTH-1:0]  src2_idx,
	input  wire                                wb_en,
	input  wire  [isa_pkg::REG_IDX_WIDTH-1:0]  wb_idx,
	input  wire                                flush,
	output logic                               stall
);
	import isa_pkg::*;

	localparam int NUM_REGS = 1 << REG_IDX_WIDTH;

	logic [NUM_REGS-1:0] pending;
	logic                need_src1;
	logic                need_src2;
	logic                need_dst;

	// Which fields the opcode depends on
	always_comb begin
		need_src1 = 1'b0;
		need_src2 = 1'b0;
		case (opcode)
			op_add, op_sub, op_and, op_or, op_xor, op_shl, op_slt: begin
				need_src1 = 1'b1;
				need_src2 = 1'b1;
			end
			op_beq, op_bne, op_put: need_src1 = 1'b1;
			default: ;
		endcase
		need_dst = writes_dst(opcode) || uses_dst_read(opcode);
	end

	assign stall = issue_valid && ((need_src1 && pending[src1_idx]) ||
		(need_src2 && pending[src2_idx]) || (need_dst && pending[dst_idx]));

	always_ff @(posedge clock) begin
		if (reset) begin
			pending <= '0;
		end else begin
			if (wb_en) begin
				pending[wb_idx] <= 1'b0;
			end
			if (issue_valid && !stall && !flush && writes_dst(opcode)) begin
				pending[dst_idx] <= 1'b1;
			end
		end
	end

	a_wb_was_pending: assert property (@(posedge clock) disable iff (reset)
		wb_en |-> pending[wb_idx]);

endmodule

`default_nettype wire

// ==== logic/instr_mem.sv ====
/*
 * Program store with a sequential write port and a registered fetch read.
 * Stores are accepted only while the unit is not running; each accepted
 * request gets a one-cycle ack_st, and the requester must drop req_st after it.
 * The store address restarts at 0 on reset and on each start.
 * fetch_instr holds its value while fetch_en is low.
 */
`timescale 1ns/100ps
`default_nettype none

module instr_mem #(
	parameter int IMEM_DEPTH = 64
) (
	input  wire                                clock,
	input  wire                                reset,
	input  wire                                req_st,
	input  wire  [isa_pkg::INSTR_WIDTH-1:0]    instr,
	input  wire                                running,
	input  wire                                restart,
	output logic                               ack_st,
	input  wire                                fetch_en,
	input  wire  [$clog2(IMEM_DEPTH)-1:0]      pc,
	output logic [isa_pkg::INSTR_WIDTH-1:0]    fetch_instr
);
	import isa_pkg::*;

	localparam int ADDR_WIDTH = $clog2(IMEM_DEPTH);

	logic [INSTR_WIDTH-1:0] mem [IMEM_DEPTH];
	logic [ADDR_WIDTH-1:0]  st_addr;
	logic                   st_take;

	// Skip the ack cycle so one request writes one word
	assign st_take = req_st && !running && !ack_st;

	always_ff @(posedge clock) begin
		if (reset) begin
			st_addr <= '0;
			ack_st  <= 1'b0;
		end else begin
			ack_st <= st_take;
			if (restart && !running) begin
				st_addr <= '0;
			end else if (st_take) begin
				st_addr <= st_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (st_take) begin
			mem[st_addr] <= instr;
		end
		if (fetch_en) begin
			fetch_instr <= mem[pc];
		end
	end

	a_ack_follows_req: assert property (@(posedge clock) disable iff (reset)
		$rose(ack_st) |-> $past(req_st));

endmodule

`default_nettype wire

// ==== logic/isa_pkg.sv ====
/*
 * Instruction set of the scalar unit.
 * Fixed 32-bit words: opcode, destination, source 1, source 2, immediate.
 * The immediate sits below source 2; li/beq/bne/jmp use it and have no source 2.
 * Opcode values outside the enum behave as nop.
 */
`default_nettype none

package isa_pkg;

	localparam int INSTR_WIDTH   = 32;
	localparam int OPCODE_WIDTH  = 4;
	localparam int REG_IDX_WIDTH = 4;
	localparam int IMM_WIDTH     = 16;

	// Field LSB positions, top down
	localparam int OPCODE_LSB = INSTR_WIDTH - OPCODE_WIDTH;
	localparam int DST_LSB    = OPCODE_LSB - REG_IDX_WIDTH;
	localparam int SRC1_LSB   = DST_LSB - REG_IDX_WIDTH;
	localparam int SRC2_LSB   = SRC1_LSB - REG_IDX_WIDTH;
	localparam int IMM_LSB    = 0;

	typedef enum logic [OPCODE_WIDTH-1:0] {
		op_nop  = 4'h0,
		op_li   = 4'h1,
		op_add  = 4'h2,
		op_sub  = 4'h3,
		op_and  = 4'h4,
		op_or   = 4'h5,
		op_xor  = 4'h6,
		op_shl  = 4'h7,
		op_slt  = 4'h8,
		op_beq  = 4'h9,
		op_bne  = 4'ha,
		op_jmp  = 4'hb,
		op_put  = 4'hc,
		op_halt = 4'hd
	} opcode_t;

	// Branches compare against the register named by the destination field
	function automatic logic uses_dst_read(opcode_t op);
		return (op == op_beq) || (op == op_bne);
	endfunction

	// Opcodes that produce a register write-back
	function automatic logic writes_dst(opcode_t op);
		return op inside {op_li, op_add, op_sub, op_and, op_or, op_xor, op_shl, op_slt};
	endfunction

endpackage

`default_nettype wire

// ==== logic/pipe_pkg.sv ====
/*
 * Pipeline control types.
 * The register file is split in two banks by the low bit of the index:
 * bank 0 holds the even registers, bank 1 the odd ones.
 */
`default_nettype none

package pipe_pkg;

	// Run state of the fetch side
	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_halted
	} run_state_t;

	localparam int NUM_BANKS = 2;

	// Registers per bank
	localparam int BANK_REGS = 8;

endpackage

`default_nettype wire

// ==== logic/reg_bank.sv ====
/*
 * One bank of the register file: two combinational reads, one write.
 * A write lands at the clock edge and is visible to reads after it.
 */
`timescale 1ns/100ps
`default_nettype none

module reg_bank #(
	parameter int DATA_WIDTH = 32
) (
	input  wire                                      clock,
	input  wire                                      reset,
	input  wire                                      we,
	input  wire  [$clog2(pipe_pkg::BANK_REGS)-1:0]   waddr,
	input  wire  [DATA_WIDTH-1:0]                    wdata,
	input  wire  [$clog2(pipe_pkg::BANK_REGS)-1:0]   raddr1,
	input  wire  [$clog2(pipe_pkg::BANK_REGS)-1:0]   raddr2,
	output logic [DATA_WIDTH-1:0]                    rdata1,
	output logic [DATA_WIDTH-1:0]                    rdata2
);
	import pipe_pkg::*;

	logic [DATA_WIDTH-1:0] regs [BANK_REGS];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < BANK_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[waddr] <= wdata;
		end
	end

	// Read ports
	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

// ==== logic/scalar_alu.sv ====
/*
 * Execute stage. Operands are captured at issue, the result and branch
 * decision form in the following cycle, and write-back leaves one cycle later.
 * redirect and halt_exec are combinational from the execute registers.
 * Arithmetic wraps; shifts use the low 5 bits of source 2.
 */
`timescale 1ns/100ps
`default_nettype none

module scalar_alu #(
	parameter int DATA_WIDTH = 32
) (
	input  wire                                clock,
	input  wire                                reset,
	input  wire                                issue,
	input  wire  isa_pkg::opcode_t             opcode,
	input  wire  [isa_pkg::REG_IDX_WIDTH-1:0]  dst_idx,
	input  wire  [isa_pkg::IMM_WIDTH-1:0]      imm,
	input  wire  [DATA_WIDTH-1:0]              src1_data,
	input  wire  [DATA_WIDTH-1:0]              src2_data,
	output logic                               redirect,
	output logic [isa_pkg::IMM_WIDTH-1:0]      redirect_addr,
	output logic                               halt_exec,
	output logic                               wb_en,
	output logic [isa_pkg::REG_IDX_WIDTH-1:0]  wb_idx,
	output logic [DATA_WIDTH-1:0]              wb_data,
	output logic                               scalar_valid,
	output logic [DATA_WIDTH-1:0]              scalar_data
);
	import isa_pkg::*;

	logic                     ex_valid;
	opcode_t                  ex_op;
	logic [REG_IDX_WIDTH-1:0] ex_dst;
	logic [IMM_WIDTH-1:0]     ex_imm;
	logic [DATA_WIDTH-1:0]    ex_a;
	logic [DATA_WIDTH-1:0]    ex_b;
	logic [DATA_WIDTH-1:0]    imm_ext;
	logic [DATA_WIDTH-1:0]    result;
	logic                     take;

	//////////////////////////////
	// Issue capture
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= issue;
		end
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			ex_op  <= opcode;
			ex_dst <= dst_idx;
			ex_imm <= imm;
			ex_a   <= src1_data;
			ex_b   <= src2_data;
		end
	end

	//////////////////////////////
	// Execute
	//////////////////////////////
	assign imm_ext = {{(DATA_WIDTH - IMM_WIDTH){ex_imm[IMM_WIDTH-1]}}, ex_imm};

	always_comb begin
		result = '0;
		take   = 1'b0;
		case (ex_op)
			op_li:  result = imm_ext;
			op_add: result = ex_a + ex_b;
			op_sub: result = ex_a - ex_b;
			op_and: result = ex_a & ex_b;
			op_or:  result = ex_a | ex_b;
			op_xor: result = ex_a ^ ex_b;
			op_shl: result = ex_a << ex_b[4:0];
			op_slt: result = DATA_WIDTH'($signed(ex_a) < $signed(ex_b));
			// ex_b carries the register named by the destination field
			op_beq: take = (ex_a == ex_b);
			op_bne: take = (ex_a != ex_b);
			op_jmp: take = 1'b1;
			default: ;
		endcase
	end

	assign redirect      = ex_valid && take;
	assign redirect_addr = ex_imm;
	assign halt_exec     = ex_valid && (ex_op == op_halt);

	//////////////////////////////
	// Write-back and output
	//////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			wb_en        <= 1'b0;
			scalar_valid <= 1'b0;
		end else begin
			wb_en        <= ex_valid && writes_dst(ex_op);
			scalar_valid <= ex_valid && (ex_op == op_put);
		end
	end

	always_ff @(posedge clock) begin
		if (ex_valid) begin
			wb_idx      <= ex_dst;
			wb_data     <= result;
			scalar_data <= ex_a;
		end
	end

endmodule

`default_nettype wire

// ==== logic/scalar_unit.sv ====
/*
 * In-order scalar unit: fetch, decode/read, execute, write-back.
 * Load a program with req_st/instr while idle or halted, then pulse start.
 * IMEM_DEPTH must be a power of two no larger than 2**16; jump targets are
 * taken modulo IMEM_DEPTH. No forwarding, so dependent instructions stall.
 * halted stays high from the executed halt until the next start.
 */
`timescale 1ns/100ps
`default_nettype none

module scalar_unit #(
	parameter int DATA_WIDTH = 32,
	parameter int IMEM_DEPTH = 64
) (
	input  wire                              clock,
	input  wire                              reset,
	input  wire                              req_st,
	input  wire  [isa_pkg::INSTR_WIDTH-1:0]  instr,
	output logic                             ack_st,
	input  wire                              start,
	output logic                             halted,
	output logic                             scalar_valid,
	output logic [DATA_WIDTH-1:0]            scalar_data
);
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int ADDR_WIDTH     = $clog2(IMEM_DEPTH);
	localparam int BANK_IDX_WIDTH = $clog2(BANK_REGS);

	logic [ADDR_WIDTH-1:0]    pc;
	logic                     fetch_en;
	logic                     fetch_valid;
	logic                     running;
	logic [INSTR_WIDTH-1:0]   fetch_instr;

	logic                     dec_valid;
	logic [INSTR_WIDTH-1:0]   dec_instr;
	opcode_t                  dec_op;
	logic [REG_IDX_WIDTH-1:0] dec_dst;
	logic [REG_IDX_WIDTH-1:0] dec_src1;
	logic [REG_IDX_WIDTH-1:0] dec_src2;
	logic [IMM_WIDTH-1:0]     dec_imm;
	logic [REG_IDX_WIDTH-1:0] rd_b_idx;
	logic                     stall;
	logic                     flush;
	logic                     issue;

	logic [DATA_WIDTH-1:0]    bank_rd_a [NUM_BANKS];
	logic [DATA_WIDTH-1:0]    bank_rd_b [NUM_BANKS];
	logic [NUM_BANKS-1:0]     bank_we;
	logic [DATA_WIDTH-1:0]    op_a;
	logic [DATA_WIDTH-1:0]    op_b;

	logic                     redirect;
	logic [IMM_WIDTH-1:0]     alu_target;
	logic [ADDR_WIDTH-1:0]    redirect_addr;
	logic                     halt_exec;
	logic                     wb_en;
	logic [REG_IDX_WIDTH-1:0] wb_idx;
	logic [DATA_WIDTH-1:0]    wb_data;

	//////////////////////////////
	// Fetch
	//////////////////////////////
	fetch_unit #(.IMEM_DEPTH(IMEM_DEPTH)) fetch (
		.clock(clock), .reset(reset), .start(start), .stall(stall),
		.redirect(redirect), .redirect_addr(redirect_addr), .halt_exec(halt_exec),
		.pc(pc), .fetch_en(fetch_en), .fetch_valid(fetch_valid),
		.running(running), .halted(halted)
	);

	instr_mem #(.IMEM_DEPTH(IMEM_DEPTH)) imem (
		.clock(clock), .reset(reset), .req_st(req_st), .instr(instr),
		.running(running), .restart(start), .ack_st(ack_st),
		.fetch_en(fetch_en), .pc(pc), .fetch_instr(fetch_instr)
	);

	//////////////////////////////
	// Decode and issue
	//////////////////////////////
	// Redirect or halt squashes both the decode slot and the word behind it
	assign flush = redirect || halt_exec;

	always_ff @(posedge clock) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else if (flush) begin
			dec_valid <= 1'b0;
		end else if (!stall) begin
			dec_valid <= fetch_valid;
		end
	end

	always_ff @(posedge clock) begin
		if (!stall) begin
			dec_instr <= fetch_instr;
		end
	end

	assign dec_op   = opcode_t'(dec_instr[OPCODE_LSB +: OPCODE_WIDTH]);
	assign dec_dst  = dec_instr[DST_LSB +: REG_IDX_WIDTH];
	assign dec_src1 = dec_instr[SRC1_LSB +: REG_IDX_WIDTH];
	assign dec_src2 = dec_instr[SRC2_LSB +: REG_IDX_WIDTH];
	assign dec_imm  = dec_instr[IMM_LSB +: IMM_WIDTH];

	// Branches read the destination register on the second port
	assign rd_b_idx = uses_dst_read(dec_op) ? dec_dst : dec_src2;
	assign issue    = dec_valid && !stall && !flush;

	hazard_check hazard (
		.clock(clock), .reset(reset), .issue_valid(dec_valid), .opcode(dec_op),
		.dst_idx(dec_dst), .src1_idx(dec_src1), .src2_idx(dec_src2),
		.wb_en(wb_en), .wb_idx(wb_idx), .flush(flush), .stall(stall)
	);

	//////////////////////////////
	// Register banks
	//////////////////////////////
	// Low index bit picks the bank, upper bits the entry
	assign bank_we[0] = wb_en && !wb_idx[0];
	assign bank_we[1] = wb_en && wb_idx[0];

	reg_bank #(.DATA_WIDTH(DATA_WIDTH)) bank_even (
		.clock(clock), .reset(reset), .we(bank_we[0]),
		.waddr(wb_idx[REG_IDX_WIDTH-1 -: BANK_IDX_WIDTH]), .wdata(wb_data),
		.raddr1(dec_src1[REG_IDX_WIDTH-1 -: BANK_IDX_WIDTH]),
		.raddr2(rd_b_idx[REG_IDX_WIDTH-1 -: BANK_IDX_WIDTH]),
		.rdata1(bank_rd_a[0]), .rdata2(bank_rd_b[0])
	);

	reg_bank #(.DATA_WIDTH(DATA_WIDTH)) bank_odd (
		.clock(clock), .reset(reset), .we(bank_we[1]),
		.waddr(wb_idx[REG_IDX_WIDTH-1 -: BANK_IDX_WIDTH]), .wdata(wb_data),
		.raddr1(dec_src1[REG_IDX_WIDTH-1 -: BANK_IDX_WIDTH]),
		.raddr2(rd_b_idx[REG_IDX_WIDTH-1 -: BANK_IDX_WIDTH]),
		.rdata1(bank_rd_a[1]), .rdata2(bank_rd_b[1])
	);

	assign op_a = bank_rd_a[dec_src1[0]];
	assign op_b = bank_rd_b[rd_b_idx[0]];

	//////////////////////////////
	// Execute
	//////////////////////////////
	scalar_alu #(.DATA_WIDTH(DATA_WIDTH)) alu (
		.clock(clock), .reset(reset), .issue(issue), .opcode(dec_op),
		.dst_idx(dec_dst), .imm(dec_imm), .src1_data(op_a), .src2_data(op_b),
		.redirect(redirect), .redirect_addr(alu_target), .halt_exec(halt_exec),
		.wb_en(wb_en), .wb_idx(wb_idx), .wb_data(wb_data),
		.scalar_valid(scalar_valid), .scalar_data(scalar_data)
	);

	// Jump target modulo memory depth
	assign redirect_addr = alu_target[ADDR_WIDTH-1:0];

endmodule

`default_nettype wire

// ==== test/clock_gen.sv ====
/*
 * Testbench clock and reset.
 * Clock starts low; reset is high from time 0 and drops after RESET_CYCLES
 * rising edges, on a rising edge.
 */
`timescale 1ns/100ps
`default_nettype none

module clock_gen #(
	parameter int HALF_PERIOD  = 10,
	parameter int RESET_CYCLES = 4
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== test/scalar_unit_tb.sv ====
/*
 * Testbench for the scalar unit.
 * Each table entry is a program with its expected put values. Programs must
 * load every register they read, since registers keep values across runs.
 * Outputs are sampled on the rising edge, inputs change just after it.
 */
`timescale 1ns/100ps
`default_nettype none

module scalar_unit_tb;
	import isa_pkg::*;

	localparam int DATA_WIDTH    = 32;
	localparam int IMEM_DEPTH    = 64;
	localparam int NUM_PROGS     = 6;
	localparam int MAX_WORDS     = 24;
	localparam int MAX_OUTS      = 8;
	localparam int STORE_TIMEOUT = 16;
	localparam int RUN_TIMEOUT   = 2000;
	localparam int RESET_TIMEOUT = 20;
	localparam int HOLD_CYCLES   = 8;

	logic                   clock;
	logic                   reset;
	logic                   req_st;
	logic [INSTR_WIDTH-1:0] instr;
	logic                   ack_st;
	logic                   start;
	logic                   halted;
	logic                   scalar_valid;
	logic [DATA_WIDTH-1:0]  scalar_data;

	// Program table
	string                  prog_name [NUM_PROGS];
	logic [INSTR_WIDTH-1:0] prog_words [NUM_PROGS][MAX_WORDS];
	int                     prog_len [NUM_PROGS];
	logic [DATA_WIDTH-1:0]  exp_vals [NUM_PROGS][MAX_OUTS];
	int                     exp_count [NUM_PROGS];
	bit                     prog_bp [NUM_PROGS];

	logic [DATA_WIDTH-1:0]  got_vals [$];
	integer                 seed;
	int                     errors;
	bit                     timed_out;

	clock_gen #(.HALF_PERIOD(10), .RESET_CYCLES(4)) clock_i (.clock(clock), .reset(reset));

	scalar_unit #(.DATA_WIDTH(DATA_WIDTH), .IMEM_DEPTH(IMEM_DEPTH)) dut_i (
		.clock(clock), .reset(reset), .req_st(req_st), .instr(instr), .ack_st(ack_st),
		.start(start), .halted(halted), .scalar_valid(scalar_valid),
		.scalar_data(scalar_data)
	);

	//////////////////////////////
	// Encoding helpers
	//////////////////////////////
	function automatic logic [31:0] enc_reg(opcode_t op, logic [3:0] d, logic [3:0] s1,
		logic [3:0] s2);
		return {op, d, s1, s2, 16'h0000};
	endfunction

	// Source 2 field left at zero
	function automatic logic [31:0] enc_imm(opcode_t op, logic [3:0] d, logic [3:0] s1,
		logic [15:0] imm);
		return {op, d, s1, 4'h0, imm};
	endfunction

	function automatic logic [31:0] sign_ext(logic [15:0] v);
		return {{16{v[15]}}, v};
	endfunction

	task automatic add_word(input int p, input logic [31:0] w);
		prog_words[p][prog_len[p]] = w;
		prog_len[p]++;
	endtask

	task automatic add_expect(input int p, input logic [31:0] v);
		exp_vals[p][exp_count[p]] = v;
		exp_count[p]++;
	endtask

	// Sum 1..5 with a bne loop; puts at 9, 10 and 12 sit behind taken branches
	task automatic add_sum_loop(input int p);
		add_word(p, enc_imm(op_li, 1, 0, 16'd0));
		add_word(p, enc_imm(op_li, 2, 0, 16'd0));
		add_word(p, enc_imm(op_li, 3, 0, 16'd5));
		add_word(p, enc_imm(op_li, 4, 0, 16'd1));
		add_word(p, enc_reg(op_add, 2, 2, 4));
		add_word(p, enc_reg(op_add, 1, 1, 2));
		add_word(p, enc_reg(op_put, 0, 1, 0));
		add_word(p, enc_imm(op_bne, 3, 2, 16'd4));
		add_word(p, enc_imm(op_beq, 3, 2, 16'd11));
		add_word(p, enc_reg(op_put, 0, 4, 0));
		add_word(p, enc_reg(op_put, 0, 4, 0));
		add_word(p, enc_imm(op_jmp, 0, 0, 16'd13));
		add_word(p, enc_reg(op_put, 0, 4, 0));
		add_word(p, enc_reg(op_halt, 0, 0, 0));
		add_expect(p, 32'd1);
		add_expect(p, 32'd3);
		add_expect(p, 32'd6);
		add_expect(p, 32'd10);
		add_expect(p, 32'd15);
	endtask

	task automatic build_programs();
		int i;
		integer rnd;
		logic [15:0] r [4];
		logic [31:0] v;
		for (i = 0; i < NUM_PROGS; i++) begin
			prog_len[i] = 0;
			exp_count[i] = 0;
			prog_bp[i] = 1'b0;
		end
		prog_name[0] = "arith";
		add_word(0, enc_imm(op_li, 1, 0, 16'hfffb));
		add_word(0, enc_imm(op_li, 2, 0, 16'h0007));
		add_word(0, enc_reg(op_add, 3, 1, 2));
		add_word(0, enc_reg(op_put, 0, 3, 0));
		add_word(0, enc_reg(op_sub, 4, 1, 2));
		add_word(0, enc_reg(op_put, 0, 4, 0));
		add_word(0, enc_reg(op_slt, 5, 1, 2));
		add_word(0, enc_reg(op_put, 0, 5, 0));
		add_word(0, enc_reg(op_slt, 6, 2, 1));
		add_word(0, enc_reg(op_put, 0, 6, 0));
		add_word(0, enc_reg(op_halt, 0, 0, 0));
		add_expect(0, 32'h0000_0002);
		add_expect(0, 32'hffff_fff4);
		add_expect(0, 32'h0000_0001);
		add_expect(0, 32'h0000_0000);
		// Even/even, even/odd and odd/odd source pairs
		prog_name[1] = "logic";
		add_word(1, enc_imm(op_li, 2, 0, 16'h00f0));
		add_word(1, enc_imm(op_li, 4, 0, 16'h0ff0));
		add_word(1, enc_imm(op_li, 3, 0, 16'h3c3c));
		add_word(1, enc_imm(op_li, 1, 0, 16'h0024));
		add_word(1, enc_reg(op_and, 5, 2, 4));
		add_word(1, enc_reg(op_put, 0, 5, 0));
		add_word(1, enc_reg(op_or, 6, 2, 3));
		add_word(1, enc_reg(op_put, 0, 6, 0));
		add_word(1, enc_reg(op_xor, 7, 4, 3));
		add_word(1, enc_reg(op_put, 0, 7, 0));
		add_word(1, enc_reg(op_shl, 8, 3, 1));
		add_word(1, enc_reg(op_put, 0, 8, 0));
		add_word(1, enc_reg(op_shl, 10, 2, 1));
		add_word(1, enc_reg(op_put, 0, 10, 0));
		add_word(1, enc_reg(op_halt, 0, 0, 0));
		add_expect(1, 32'h0000_00f0);
		add_expect(1, 32'h0000_3cfc);
		add_expect(1, 32'h0000_33cc);
		add_expect(1, 32'h0003_c3c0);
		add_expect(1, 32'h0000_0f00);
		prog_name[2] = "dependent";
		add_word(2, enc_imm(op_li, 1, 0, 16'd3));
		add_word(2, enc_reg(op_add, 2, 1, 1));
		add_word(2, enc_reg(op_add, 3, 2, 1));
		add_word(2, enc_reg(op_put, 0, 3, 0));
		add_word(2, enc_reg(op_sub, 4, 3, 2));
		add_word(2, enc_reg(op_add, 4, 4, 4));
		add_word(2, enc_reg(op_put, 0, 4, 0));
		add_word(2, enc_reg(op_shl, 5, 4, 1));
		add_word(2, enc_reg(op_xor, 6, 5, 3));
		add_word(2, enc_reg(op_put, 0, 6, 0));
		add_word(2, enc_imm(op_li, 7, 0, 16'd1));
		add_word(2, enc_imm(op_li, 7, 0, 16'd2));
		add_word(2, enc_reg(op_put, 0, 7, 0));
		add_word(2, enc_reg(op_halt, 0, 0, 0));
		add_expect(2, 32'd9);
		add_expect(2, 32'd6);
		add_expect(2, 32'h39);
		add_expect(2, 32'd2);
		prog_name[3] = "branch loop";
		add_sum_loop(3);
		prog_name[4] = "random imm";
		for (i = 0; i < 4; i++) begin
			rnd = $random(seed);
			r[i] = rnd[15:0];
		end
		add_word(4, enc_imm(op_li, 1, 0, r[0]));
		add_word(4, enc_imm(op_li, 2, 0, r[1]));
		add_word(4, enc_imm(op_li, 3, 0, r[2]));
		add_word(4, enc_imm(op_li, 8, 0, r[3]));
		add_word(4, enc_reg(op_add, 4, 1, 2));
		add_word(4, enc_reg(op_put, 0, 4, 0));
		add_word(4, enc_reg(op_xor, 5, 4, 3));
		add_word(4, enc_reg(op_put, 0, 5, 0));
		add_word(4, enc_reg(op_add, 6, 5, 8));
		add_word(4, enc_reg(op_put, 0, 6, 0));
		add_word(4, enc_reg(op_xor, 7, 6, 1));
		add_word(4, enc_reg(op_put, 0, 7, 0));
		add_word(4, enc_reg(op_halt, 0, 0, 0));
		v = sign_ext(r[0]) + sign_ext(r[1]);
		add_expect(4, v);
		v = v ^ sign_ext(r[2]);
		add_expect(4, v);
		v = v + sign_ext(r[3]);
		add_expect(4, v);
		v = v ^ sign_ext(r[0]);
		add_expect(4, v);
		// Store requests during the run, then a second start
		prog_name[5] = "store backpressure";
		add_sum_loop(5);
		prog_bp[5] = 1'b1;
	endtask

	//////////////////////////////
	// Bus tasks
	//////////////////////////////
	task automatic wait_for_reset();
		int cycles;
		cycles = 0;
		@(posedge clock);
		while (reset && cycles < RESET_TIMEOUT) begin
			@(posedge clock);
			cycles++;
		end
		if (reset) begin
			$display("reset was still high after %0d cycles", RESET_TIMEOUT);
			timed_out = 1'b1;
		end
	endtask

	task automatic store_program(input int p);
		int w;
		int cycles;
		bit got;
		for (w = 0; w < prog_len[p] && !timed_out; w++) begin
			@(posedge clock);
			req_st <= 1'b1;
			instr  <= prog_words[p][w];
			got = 1'b0;
			cycles = 0;
			while (!got && cycles < STORE_TIMEOUT) begin
				@(posedge clock);
				cycles++;
				if (ack_st) got = 1'b1;
			end
			req_st <= 1'b0;
			if (!got) begin
				$display("no ack_st for word %0d of %s", w, prog_name[p]);
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic pulse_start();
		@(posedge clock);
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;
	endtask

	task automatic run_and_collect(input int p, input bit hold_req);
		int cycles;
		bit done;
		cycles = 0;
		done = 1'b0;
		got_vals.delete();
		// A halt word at address 0 would spoil the rerun if it got stored
		if (hold_req) begin
			req_st <= 1'b1;
			instr  <= enc_reg(op_halt, 0, 0, 0);
		end
		while (!done && cycles < RUN_TIMEOUT) begin
			@(posedge clock);
			cycles++;
			if (ack_st) begin
				$display("Fail ack_st during run of %s: got %h expected %h",
					prog_name[p], ack_st, 1'b0);
				errors++;
			end
			if (hold_req && cycles == HOLD_CYCLES) req_st <= 1'b0;
			if (scalar_valid) got_vals.push_back(scalar_data);
			if (halted) done = 1'b1;
		end
		if (!done) begin
			$display("%s did not halt within %0d cycles", prog_name[p], RUN_TIMEOUT);
			timed_out = 1'b1;
		end
	endtask

	task automatic check_outputs(input int p, input string phase);
		int i;
		if (got_vals.size() != exp_count[p]) begin
			$display("Fail scalar_valid count in %s %s: got %h expected %h",
				prog_name[p], phase, got_vals.size(), exp_count[p]);
			errors++;
		end
		for (i = 0; i < exp_count[p] && i < got_vals.size(); i++) begin
			if (got_vals[i] !== exp_vals[p][i]) begin
				$display("Fail scalar_data[%0d] in %s %s: got %h expected %h",
					i, prog_name[p], phase, got_vals[i], exp_vals[p][i]);
				errors++;
			end
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		int p;
		int errs_before;
		int progs_run;
		int progs_failed;
		req_st <= 1'b0;
		instr  <= '0;
		start  <= 1'b0;
		errors = 0;
		timed_out = 1'b0;
		progs_run = 0;
		progs_failed = 0;
		seed = 42896;
		build_programs();
		wait_for_reset();
		if (!timed_out && (ack_st !== 1'b0 || scalar_valid !== 1'b0 || halted !== 1'b0)) begin
			$display("Fail outputs after reset: ack_st %h scalar_valid %h halted %h expected 0",
				ack_st, scalar_valid, halted);
			errors++;
		end
		for (p = 0; p < NUM_PROGS && !timed_out; p++) begin
			errs_before = errors;
			store_program(p);
			if (!timed_out) begin
				pulse_start();
				run_and_collect(p, prog_bp[p]);
			end
			if (!timed_out) check_outputs(p, "run");
			if (!timed_out && prog_bp[p]) begin
				pulse_start();
				run_and_collect(p, 1'b0);
				if (!timed_out) check_outputs(p, "rerun");
			end
			progs_run++;
			if (errors != errs_before || timed_out) begin
				progs_failed++;
				$display("test %0d %s: FAILED", p, prog_name[p]);
			end else begin
				$display("test %0d %s: ok", p, prog_name[p]);
			end
		end
		$display("programs run %0d, passed %0d, failed %0d, check errors %0d",
			progs_run, progs_run - progs_failed, progs_failed, errors);
		if (errors == 0 && !timed_out) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
